/* include/xt_periph_settings.svh */
// ======================================================================
// Port addresses, EMS window bases and register reset values.
// Port constants are 16-bit ISA I/O addresses; upper address bits ignored.
// ======================================================================

`ifndef XT_PERIPH_SETTINGS_SVH
`define XT_PERIPH_SETTINGS_SVH

// EMS page registers at 260h..263h
`define XT_EMS_PORT_BASE    16'h0260

// Printer data latch
`define XT_LPT_PORT         16'h0378

// Tandy video page register
`define XT_TANDY_PAGE_PORT  16'h03DF

// NMI mask block, A0h..A7h, Tandy only
`define XT_NMI_PORT_BASE    16'h00A0

// Top nibble of the EMS window per ems_window code
`define XT_EMS_SEG_A        4'hA
`define XT_EMS_SEG_C        4'hC
`define XT_EMS_SEG_D        4'hD

// Writing this value to a page register unmaps the page
`define XT_EMS_UNMAP_CODE   8'hFF

`define XT_LATCH_RESET      8'hFF
`define XT_NMI_RESET        8'hFF
`define XT_PAGE_RESET       8'h00

`endif

/* src/xt_periph_pkg.sv */
// ======================================================================
// Shared types for the XT peripheral glue logic.
// Device codes are exclusive; DEV_NONE means no latch or EMS port hit.
// ======================================================================

package xt_periph_pkg;

    // I/O device chosen by the port decoder
    typedef enum logic [2:0] {
        DEV_NONE,
        DEV_EMS,
        DEV_LPT,
        DEV_TANDY_PAGE,
        DEV_NMI_MASK
    } io_device_e;

    // Effect of a write to one of the EMS page ports
    //   EMS_UNMAP  data FFh, page disabled
    //   EMS_MAP    data below 80h, page enabled
    //   EMS_KEEP   anything else, entry left alone
    typedef enum logic [1:0] {
        EMS_KEEP,
        EMS_MAP,
        EMS_UNMAP
    } ems_cmd_e;

    // One entry of the EMS page map, 16 KB pages
    typedef logic [6:0] ems_page_t;

endpackage

/* src/io_port_decoder.sv */
// ======================================================================
// Combinational I/O decoder. Only address bits 15:0 take part in port
// compares. Selects are valid only while an I/O strobe is low.
// ======================================================================

`timescale 1ns/1ps

`include "xt_periph_settings.svh"

module io_port_decoder (
    input  logic [19:0]                 address_i,
    input  logic                        address_enable_n_i,
    input  logic                        io_read_n_i,
    input  logic                        io_write_n_i,
    input  logic                        tandy_video_i,
    input  logic                        ems_enabled_i,
    output xt_periph_pkg::io_device_e   device_o,
    output logic [7:0]                  chip_select_n_o,
    output logic                        memory_cycle_o
);
    import xt_periph_pkg::*;

    localparam logic [15:0] EMS_BASE   = `XT_EMS_PORT_BASE;
    localparam logic [15:0] LPT_PORT   = `XT_LPT_PORT;
    localparam logic [15:0] PAGE_PORT  = `XT_TANDY_PAGE_PORT;
    localparam logic [15:0] NMI_BASE   = `XT_NMI_PORT_BASE;

    logic io_request;
    logic io_cycle;
    logic low_block;
    logic ems_hit;
    logic lpt_hit;
    logic page_hit;
    logic nmi_hit;

    assign io_request = ~io_read_n_i | ~io_write_n_i;
    assign io_cycle   = io_request & ~address_enable_n_i;

    // No I/O strobe means the bus is doing a memory access
    assign memory_cycle_o = io_read_n_i & io_write_n_i;

    // Ports 000h..0FFh split into eight blocks of 32
    assign low_block = io_cycle & (address_i[9:8] == 2'b00);

    always_comb begin
        chip_select_n_o = 8'hFF;
        if (low_block) begin
            chip_select_n_o[address_i[7:5]] = 1'b0;
        end
    end

    // Full port compares
    assign ems_hit  = ems_enabled_i & (address_i[15:2] == EMS_BASE[15:2]);
    assign lpt_hit  = (address_i[15:0] == LPT_PORT);
    assign page_hit = (address_i[15:0] == PAGE_PORT);
    assign nmi_hit  = tandy_video_i & (address_i[15:3] == NMI_BASE[15:3]);

    // The port ranges never overlap
    always_comb begin
        device_o = DEV_NONE;
        if (io_cycle) begin
            if (ems_hit) begin
                device_o = DEV_EMS;
            end
            else if (lpt_hit) begin
                device_o = DEV_LPT;
            end
            else if (page_hit) begin
                device_o = DEV_TANDY_PAGE;
            end
            else if (nmi_hit) begin
                device_o = DEV_NMI_MASK;
            end
        end
    end

endmodule

/* src/peripheral_register_bank.sv */
// ======================================================================
// EMS page map and the printer, Tandy page and NMI mask latches.
// Latch writes land in 1 cycle, EMS map writes in 2 (command, then map).
// Map contents are undefined until a slot is written; enables reset to 0.
// ======================================================================

`timescale 1ns/1ps

`include "xt_periph_settings.svh"

module peripheral_register_bank (
    input  logic                        clock,
    input  logic                        reset,
    input  xt_periph_pkg::io_device_e   device_i,
    input  logic                        memory_cycle_i,
    input  logic                        io_write_n_i,
    input  logic [19:0]                 address_i,
    input  logic [7:0]                  data_i,
    input  logic [1:0]                  ems_window_i,
    output logic [7:0]                  ems_readback_o,
    output logic [7:0]                  lpt_data_o,
    output logic [7:0]                  tandy_page_o,
    output logic [7:0]                  nmi_mask_o,
    output logic [3:0]                  ems_block_hit_o
);
    import xt_periph_pkg::*;

    ems_cmd_e   ems_cmd;
    ems_cmd_e   ems_cmd_q;
    logic [1:0] ems_slot_q;
    ems_page_t  ems_data_q;
    logic       ems_write_q;

    ems_page_t  ems_map_q [4];
    logic [3:0] ems_enable_q;
    logic [3:0] window_base;

    // Classify the incoming byte
    always_comb begin
        if (data_i == `XT_EMS_UNMAP_CODE) begin
            ems_cmd = EMS_UNMAP;
        end
        else if (!data_i[7]) begin
            ems_cmd = EMS_MAP;
        end
        else begin
            ems_cmd = EMS_KEEP;
        end
    end

    // Stage 1: capture the command
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            ems_write_q <= 1'b0;
        end
        else begin
            ems_write_q <= (device_i == DEV_EMS) & ~io_write_n_i;
        end
    end

    always_ff @(posedge clock) begin
        ems_slot_q <= address_i[1:0];
        ems_cmd_q  <= ems_cmd;
        ems_data_q <= data_i[6:0];
    end

    // Stage 2: apply it to the selected slot
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            ems_enable_q <= 4'b0000;
        end
        else if (ems_write_q) begin
            if (ems_cmd_q == EMS_UNMAP) begin
                ems_enable_q[ems_slot_q] <= 1'b0;
            end
            else if (ems_cmd_q == EMS_MAP) begin
                ems_enable_q[ems_slot_q] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (ems_write_q) begin
            if (ems_cmd_q == EMS_UNMAP) begin
                ems_map_q[ems_slot_q] <= 7'h7F;
            end
            else if (ems_cmd_q == EMS_MAP) begin
                ems_map_q[ems_slot_q] <= ems_data_q;
            end
        end
    end

    // Disabled slots read back as FFh
    assign ems_readback_o = ems_enable_q[address_i[1:0]] ?
                            {1'b0, ems_map_q[address_i[1:0]]} : 8'hFF;

    always_comb begin
        unique case (ems_window_i)
            2'd0:    window_base = `XT_EMS_SEG_A;
            2'd1:    window_base = `XT_EMS_SEG_C;
            default: window_base = `XT_EMS_SEG_D;
        endcase
    end

    // Slot n covers the n-th 16 KB block of the 64 KB window
    always_comb begin
        for (int n = 0; n < 4; n++) begin
            ems_block_hit_o[n] = memory_cycle_i & ems_enable_q[n] &
                                 (address_i[19:14] == {window_base, n[1:0]});
        end
    end

    // Plain byte latches
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            lpt_data_o   <= `XT_LATCH_RESET;
            tandy_page_o <= `XT_PAGE_RESET;
            nmi_mask_o   <= `XT_NMI_RESET;
        end
        else if (~io_write_n_i) begin
            if (device_i == DEV_LPT) begin
                lpt_data_o <= data_i;
            end
            if (device_i == DEV_TANDY_PAGE) begin
                tandy_page_o <= data_i;
            end
            if (device_i == DEV_NMI_MASK) begin
                nmi_mask_o <= data_i;
            end
        end
    end

endmodule

/* src/bus_read_mux.sv */
// ======================================================================
// Registered read-back onto the CPU data bus. data_o is 00h and the
// chipset flag low on any cycle without a decoded read.
// ======================================================================

`timescale 1ns/1ps

module bus_read_mux (
    input  logic                        clock,
    input  logic                        reset,
    input  xt_periph_pkg::io_device_e   device_i,
    input  logic                        io_read_n_i,
    input  logic [7:0]                  ems_readback_i,
    input  logic [7:0]                  lpt_data_i,
    input  logic [7:0]                  tandy_page_i,
    input  logic [7:0]                  nmi_mask_i,
    output logic [7:0]                  data_o,
    output logic                        data_from_chipset_o
);
    import xt_periph_pkg::*;

    logic       read_hit;
    logic [7:0] read_data;

    assign read_hit = ~io_read_n_i & (device_i != DEV_NONE);

    // Decoder codes are exclusive, so one source at a time
    always_comb begin
        unique case (device_i)
            DEV_EMS:        read_data = ems_readback_i;
            DEV_LPT:        read_data = lpt_data_i;
            DEV_TANDY_PAGE: read_data = tandy_page_i;
            DEV_NMI_MASK:   read_data = nmi_mask_i;
            default:        read_data = 8'h00;
        endcase
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            data_o              <= 8'h00;
            data_from_chipset_o <= 1'b0;
        end
        else if (read_hit) begin
            data_o              <= read_data;
            data_from_chipset_o <= 1'b1;
        end
        else begin
            // Release the bus
            data_o              <= 8'h00;
            data_from_chipset_o <= 1'b0;
        end
    end

endmodule

/* src/xt_peripherals.sv */
// ======================================================================
// XT peripheral glue: port decoder, EMS/latch registers, read-back mux.
// External chips are not included; their selects leave on chip_select_n_o.
// ======================================================================

`timescale 1ns/1ps

module xt_peripherals (
    input  logic        clock,
    input  logic        reset,
    input  logic [19:0] address_i,
    input  logic        address_enable_n_i,
    input  logic        io_read_n_i,
    input  logic        io_write_n_i,
    input  logic [7:0]  data_i,
    input  logic        tandy_video_i,
    input  logic        ems_enabled_i,
    input  logic [1:0]  ems_window_i,
    output logic [7:0]  data_o,
    output logic        data_from_chipset_o,
    output logic [7:0]  chip_select_n_o,
    output logic [3:0]  ems_block_hit_o,
    output logic [7:0]  lpt_data_o,
    output logic [7:0]  tandy_page_o,
    output logic [7:0]  nmi_mask_o
);
    import xt_periph_pkg::*;

    io_device_e device;
    logic       memory_cycle;
    logic [7:0] ems_readback;

    io_port_decoder u_decoder (
        .address_i          (address_i),
        .address_enable_n_i (address_enable_n_i),
        .io_read_n_i        (io_read_n_i),
        .io_write_n_i       (io_write_n_i),
        .tandy_video_i      (tandy_video_i),
        .ems_enabled_i      (ems_enabled_i),
        .device_o           (device),
        .chip_select_n_o    (chip_select_n_o),
        .memory_cycle_o     (memory_cycle)
    );

    peripheral_register_bank u_registers (
        .clock              (clock),
        .reset              (reset),
        .device_i           (device),
        .memory_cycle_i     (memory_cycle),
        .io_write_n_i       (io_write_n_i),
        .address_i          (address_i),
        .data_i             (data_i),
        .ems_window_i       (ems_window_i),
        .ems_readback_o     (ems_readback),
        .lpt_data_o         (lpt_data_o),
        .tandy_page_o       (tandy_page_o),
        .nmi_mask_o         (nmi_mask_o),
        .ems_block_hit_o    (ems_block_hit_o)
    );

    bus_read_mux u_read_mux (
        .clock               (clock),
        .reset               (reset),
        .device_i            (device),
        .io_read_n_i         (io_read_n_i),
        .ems_readback_i      (ems_readback),
        .lpt_data_i          (lpt_data_o),
        .tandy_page_i        (tandy_page_o),
        .nmi_mask_i          (nmi_mask_o),
        .data_o              (data_o),
        .data_from_chipset_o (data_from_chipset_o)
    );

endmodule

/* testbench/xt_periph_assertions.sv */
// ======================================================================
// Protocol checks bound into xt_peripherals. Checks are off in reset.
// ======================================================================

`timescale 1ns/1ps

module xt_periph_assertions (
    input logic       clock,
    input logic       reset,
    input logic       io_read_n_i,
    input logic       io_write_n_i,
    input logic       data_from_chipset_o,
    input logic [3:0] ems_block_hit_o
);

    // No read strobe on the last edge, so nothing may be driven now
    assert property (@(posedge clock) disable iff (reset)
        $past(io_read_n_i) |-> !data_from_chipset_o)
        else $error("chipset flag set without a read strobe one cycle earlier");

    // EMS windows only decode memory cycles
    assert property (@(posedge clock) disable iff (reset)
        (!io_read_n_i || !io_write_n_i) |-> (ems_block_hit_o == 4'b0000))
        else $error("EMS window hit during an I/O cycle");

    assert property (@(posedge clock) disable iff (reset)
        $onehot0(ems_block_hit_o))
        else $error("more than one EMS window hit");

endmodule

bind xt_peripherals xt_periph_assertions u_assertions (
    .clock               (clock),
    .reset               (reset),
    .io_read_n_i         (io_read_n_i),
    .io_write_n_i        (io_write_n_i),
    .data_from_chipset_o (data_from_chipset_o),
    .ems_block_hit_o     (ems_block_hit_o)
);

/* testbench/xt_periph_tb.sv */
// ======================================================================
// Directed tests for xt_peripherals. Inputs change on the falling edge
// and outputs are sampled on the following falling edge.
// ======================================================================

`timescale 1ns/1ps

module xt_periph_tb;

    localparam int TIMEOUT_CYCLES = 400;

    logic        clock;
    logic        reset;
    logic [19:0] address;
    logic        address_enable_n;
    logic        io_read_n;
    logic        io_write_n;
    logic [7:0]  data_in;
    logic        tandy_video;
    logic        ems_enabled;
    logic [1:0]  ems_window;
    logic [7:0]  data_out;
    logic        data_from_chipset;
    logic [7:0]  chip_select_n;
    logic [3:0]  ems_block_hit;
    logic [7:0]  lpt_data;
    logic [7:0]  tandy_page;
    logic [7:0]  nmi_mask;

    // Results of the last bus cycle
    logic [7:0]  value;
    logic        flag;
    logic [7:0]  selects;
    logic [3:0]  hits;

    integer      seed;
    logic [31:0] rnd;
    int          error_count;
    int          failed_tests;
    int          cycle_count;
    int          start;

    xt_peripherals UUT (
        .clock               (clock),
        .reset               (reset),
        .address_i           (address),
        .address_enable_n_i  (address_enable_n),
        .io_read_n_i         (io_read_n),
        .io_write_n_i        (io_write_n),
        .data_i              (data_in),
        .tandy_video_i       (tandy_video),
        .ems_enabled_i       (ems_enabled),
        .ems_window_i        (ems_window),
        .data_o              (data_out),
        .data_from_chipset_o (data_from_chipset),
        .chip_select_n_o     (chip_select_n),
        .ems_block_hit_o     (ems_block_hit),
        .lpt_data_o          (lpt_data),
        .tandy_page_o        (tandy_page),
        .nmi_mask_o          (nmi_mask)
    );

    always #4 clock = ~clock;

    // Tests need about 190 cycles
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic report_error(input string what, input logic [7:0] got,
                                input logic [7:0] expected);
        $display("** Error at %0t ns: %s is %02h, expected %02h", $time, what, got, expected);
        error_count++;
    endtask

    task automatic report_test(input int number, input string name);
        if (error_count == start) begin
            $display("Test %0d %s: passed", number, name);
        end
        else begin
            $display("Test %0d %s: %0d errors", number, name, error_count - start);
            failed_tests++;
        end
    endtask

    // One I/O cycle, one clock long; results taken just before the strobe drops
    task automatic bus_cycle(input logic write, input logic [19:0] port,
                             input logic [7:0] byte_out);
        @(negedge clock);
        address          = port;
        data_in          = byte_out;
        address_enable_n = 1'b0;
        io_write_n       = ~write;
        io_read_n        = write;
        @(negedge clock);
        value            = data_out;
        flag             = data_from_chipset;
        selects          = chip_select_n;
        io_write_n       = 1'b1;
        io_read_n        = 1'b1;
        address_enable_n = 1'b1;
    endtask

    task automatic memory_hits(input logic [19:0] location);
        @(negedge clock);
        address = location;
        @(negedge clock);
        hits = ems_block_hit;
    endtask

    task automatic check_reset_values();
        start = error_count;
        if (lpt_data !== 8'hFF) report_error("printer latch", lpt_data, 8'hFF);
        if (nmi_mask !== 8'hFF) report_error("NMI mask", nmi_mask, 8'hFF);
        if (tandy_page !== 8'h00) report_error("Tandy page", tandy_page, 8'h00);
        if (data_out !== 8'h00) report_error("read data", data_out, 8'h00);
        if (data_from_chipset !== 1'b0) begin
            report_error("chipset flag", {7'b0, data_from_chipset}, 8'h00);
        end
        if (ems_block_hit !== 4'h0) report_error("EMS hits", {4'h0, ems_block_hit}, 8'h00);
        for (int slot = 0; slot < 4; slot++) begin
            bus_cycle(1'b0, 20'h00260 + 20'(slot), 8'h00);
            if (value !== 8'hFF) report_error("unmapped EMS readback", value, 8'hFF);
            if (flag !== 1'b1) report_error("EMS read flag", {7'b0, flag}, 8'h01);
        end
        report_test(1, "reset values");
    endtask

    task automatic decode_chip_selects();
        logic [7:0] expected;
        start = error_count;
        for (int i = 0; i < 64; i++) begin
            rnd = $random(seed);
            bus_cycle(1'b1, {12'h000, rnd[7:0]}, 8'h00);
            expected = ~(8'h01 << rnd[7:5]);
            if (selects !== expected) report_error("chip selects", selects, expected);
        end
        bus_cycle(1'b0, 20'h00378, 8'h00);
        if (selects !== 8'hFF) report_error("chip selects on 378h", selects, 8'hFF);
        report_test(2, "chip selects");
    endtask

    task automatic latch_readback();
        start = error_count;
        rnd = $random(seed);
        bus_cycle(1'b1, 20'h00378, rnd[7:0]);
        bus_cycle(1'b1, 20'h003DF, rnd[15:8]);
        bus_cycle(1'b0, 20'h00378, 8'h00);
        if (value !== rnd[7:0]) report_error("printer readback", value, rnd[7:0]);
        bus_cycle(1'b0, 20'h003DF, 8'h00);
        if (value !== rnd[15:8]) report_error("Tandy page readback", value, rnd[15:8]);
        // NMI mask port is only decoded in Tandy mode
        bus_cycle(1'b1, 20'h000A0, 8'h5A);
        if (nmi_mask !== 8'hFF) report_error("NMI mask without Tandy", nmi_mask, 8'hFF);
        bus_cycle(1'b0, 20'h000A0, 8'h00);
        if (flag !== 1'b0) report_error("read flag without Tandy", {7'b0, flag}, 8'h00);
        tandy_video = 1'b1;
        bus_cycle(1'b1, 20'h000A0, 8'h5A);
        if (nmi_mask !== 8'h5A) report_error("NMI mask in Tandy mode", nmi_mask, 8'h5A);
        bus_cycle(1'b0, 20'h000A0, 8'h00);
        if (value !== 8'h5A) report_error("NMI mask readback", value, 8'h5A);
        tandy_video = 1'b0;
        report_test(3, "byte latches");
    endtask

    task automatic ems_map_and_hit();
        start = error_count;
        ems_window = 2'd1;
        bus_cycle(1'b1, 20'h00261, 8'h05);
        repeat (2) @(negedge clock);
        bus_cycle(1'b0, 20'h00261, 8'h00);
        if (value !== 8'h05) report_error("EMS readback after map", value, 8'h05);
        memory_hits(20'hC4000);
        if (hits !== 4'b0010) report_error("hits at C4000h", {4'h0, hits}, 8'h02);
        memory_hits(20'hC0000);
        if (hits !== 4'b0000) report_error("hits at C0000h", {4'h0, hits}, 8'h00);
        report_test(4, "EMS map");
    endtask

    task automatic ems_keep_and_unmap();
        start = error_count;
        bus_cycle(1'b1, 20'h00261, 8'h90);
        repeat (2) @(negedge clock);
        bus_cycle(1'b0, 20'h00261, 8'h00);
        if (value !== 8'h05) report_error("EMS readback after keep", value, 8'h05);
        bus_cycle(1'b1, 20'h00261, 8'hFF);
        repeat (2) @(negedge clock);
        bus_cycle(1'b0, 20'h00261, 8'h00);
        if (value !== 8'hFF) report_error("EMS readback after unmap", value, 8'hFF);
        for (int n = 0; n < 4; n++) begin
            memory_hits(20'hC0000 + 20'(n * 20'h04000));
            if (hits !== 4'b0000) report_error("hits after unmap", {4'h0, hits}, 8'h00);
        end
        report_test(5, "EMS keep and unmap");
    endtask

    initial begin
        clock            = 1'b0;
        reset            = 1'b1;
        address          = 20'h00000;
        address_enable_n = 1'b1;
        io_read_n        = 1'b1;
        io_write_n       = 1'b1;
        data_in          = 8'h00;
        tandy_video      = 1'b0;
        ems_enabled      = 1'b1;
        ems_window       = 2'd0;
        seed             = 32'hb5f8b0a5;
        error_count      = 0;
        failed_tests     = 0;
        cycle_count      = 0;
        start            = 0;
        repeat (3) @(negedge clock);
        reset = 1'b0;
        check_reset_values();
        decode_chip_selects();
        latch_readback();
        ems_map_and_hit();
        ems_keep_and_unmap();
        $display("Tests run: 5, failed: %0d, errors: %0d", failed_tests, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end
        else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+include
src/xt_periph_pkg.sv
src/io_port_decoder.sv
src/peripheral_register_bank.sv
src/bus_read_mux.sv
src/xt_peripherals.sv
testbench/xt_periph_assertions.sv
testbench/xt_periph_tb.sv

/* Makefile */
# Verilator build and run for the XT peripheral glue logic

VERILATOR  ?= verilator
TOP        := xt_periph_tb
FILE_LIST  := sim.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

# The run result is taken from the log, not from the exit status
run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "No final report in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
